// File: source/fetch_config.svh
/* fetch stage configuration macros
   word width, prefetch depth, start address and reset instruction */

`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// address and instruction width
`define FETCH_XLEN 32

// prefetch buffer entries, power of two
`define FETCH_BUF_DEPTH 4

// first fetch after power-on or system reset
`define FETCH_START_ADDR 32'h0000_0100

// addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

`endif

// File: source/fetch_pkg.sv
/* shared fetch types
   word, prefetch entry and buffer occupancy count */

`include "fetch_config.svh"

package fetch_pkg;

    //////////////////////////////////////////////////
    // basic word
    //////////////////////////////////////////////////

    // one address or one instruction
    typedef logic [`FETCH_XLEN-1:0] word_t;

    //////////////////////////////////////////////////
    // prefetch buffer payload
    //////////////////////////////////////////////////

    // fetched word with the address it came from
    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_entry_t;

    // holds 0 up to the full depth
    typedef logic [$clog2(`FETCH_BUF_DEPTH+1)-1:0] buf_count_t;

endpackage

// File: source/fetch_sequencer.sv
/* fetch request sequencer
   fetch address, memory request, in-flight tracking, redirect and flush */

`include "fetch_config.svh"

module fetch_sequencer (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    sys_reset_i,
    input  logic                    jump_i,
    input  logic                    ctx_switch_i,
    input  logic                    busy_i,
    input  fetch_pkg::word_t        jump_target_i,
    input  fetch_pkg::word_t        ctx_switch_target_i,
    input  fetch_pkg::word_t        instr_data_i,
    input  fetch_pkg::buf_count_t   free_count_i,
    output logic                    fetch_req_o,
    output fetch_pkg::word_t        fetch_addr_o,
    output logic                    flush_o,
    output logic                    push_o,
    output fetch_pkg::fetch_entry_t push_entry_o
);

    localparam int XLEN = `FETCH_XLEN;
    localparam fetch_pkg::word_t START_ADDR = `FETCH_START_ADDR;

    // word addresses, byte offset implied zero
    logic [XLEN-1:2] fetch_word_q;
    logic [XLEN-1:2] pend_word_q;
    logic [XLEN-1:2] redirect_word;

    // one response in flight at most
    logic pend_q;

    logic                  redirect;
    logic                  accept;
    fetch_pkg::buf_count_t pend_count;

    //////////////////////////////////////////////////
    // redirect
    //////////////////////////////////////////////////

    assign redirect = sys_reset_i || ctx_switch_i || jump_i;

    // system reset over context switch over jump
    always_comb begin
        if (sys_reset_i) begin
            redirect_word = START_ADDR[XLEN-1:2];
        end else if (ctx_switch_i) begin
            redirect_word = ctx_switch_target_i[XLEN-1:2];
        end else begin
            redirect_word = jump_target_i[XLEN-1:2];
        end
    end

    // buffer and issue drop everything on redirect
    assign flush_o = redirect;

    //////////////////////////////////////////////////
    // memory request
    //////////////////////////////////////////////////

    // response still due takes a slot of its own
    assign pend_count = fetch_pkg::buf_count_t'(pend_q);

    // request only while a slot is left after the response in flight
    assign fetch_req_o  = !redirect && (free_count_i > pend_count);
    assign accept       = fetch_req_o && !busy_i;
    assign fetch_addr_o = {fetch_word_q, 2'b00};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fetch_word_q <= START_ADDR[XLEN-1:2];
        end else if (redirect) begin
            fetch_word_q <= redirect_word;
        end else if (accept) begin
            // next sequential word
            fetch_word_q <= fetch_word_q + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // in-flight tracking
    //////////////////////////////////////////////////

    // redirect drops the response of the old stream
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pend_q <= 1'b0;
        end else if (redirect) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= accept;
        end
    end

    // address of the word on its way back
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pend_word_q <= '0;
        end else if (accept) begin
            pend_word_q <= fetch_word_q;
        end
    end

    // response valid exactly one cycle after acceptance
    assign push_o             = pend_q && !redirect;
    assign push_entry_o.pc    = {pend_word_q, 2'b00};
    assign push_entry_o.instr = instr_data_i;

endmodule

// File: source/fetch_buffer.sv
/* prefetch ring buffer of fetch entries
   flush, push, pop and free-slot count */

`include "fetch_config.svh"

module fetch_buffer (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    flush_i,
    input  logic                    push_i,
    input  logic                    pop_i,
    input  fetch_pkg::fetch_entry_t push_entry_i,
    output logic                    head_valid_o,
    output fetch_pkg::fetch_entry_t head_entry_o,
    output fetch_pkg::buf_count_t   free_count_o
);

    localparam int DEPTH = `FETCH_BUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam fetch_pkg::buf_count_t FULL_COUNT = fetch_pkg::buf_count_t'(DEPTH);

    // entry storage
    fetch_pkg::fetch_entry_t mem [DEPTH];

    // pointers wrap on their own with power of two depth
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [PTR_W-1:0]      wr_ptr_q;
    fetch_pkg::buf_count_t count_q;

    logic full;
    logic do_push;
    logic do_pop;

    //////////////////////////////////////////////////
    // status
    //////////////////////////////////////////////////

    assign full         = (count_q == FULL_COUNT);
    assign head_valid_o = (count_q != '0);
    assign free_count_o = FULL_COUNT - count_q;

    // pop of an empty buffer is ignored
    assign do_pop  = pop_i && head_valid_o;
    // full buffer still takes a push alongside a pop
    assign do_push = push_i && (!full || do_pop);

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (do_push && !flush_i) begin
            mem[wr_ptr_q] <= push_entry_i;
        end
    end

    // oldest entry
    assign head_entry_o = mem[rd_ptr_q];

    //////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // flush beats push and pop
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // push and pop together leave count alone
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// File: source/fetch_issue.sv
/* issue register toward decode
   valid, pc, instruction and jumping flag under decode back-pressure */

`include "fetch_config.svh"

module fetch_issue (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    enable_i,
    input  logic                    flush_i,
    input  logic                    head_valid_i,
    input  fetch_pkg::fetch_entry_t head_entry_i,
    output logic                    pop_o,
    output logic                    valid_o,
    output logic                    jumping_o,
    output fetch_pkg::word_t        pc_o,
    output fetch_pkg::word_t        instruction_o
);

    //////////////////////////////////////////////////
    // buffer side
    //////////////////////////////////////////////////

    // take the head on an enabled edge
    // nothing taken while the stream is being flushed
    assign pop_o = enable_i && head_valid_i && !flush_i;

    //////////////////////////////////////////////////
    // decode side
    //////////////////////////////////////////////////

    // valid and jumping flag
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o   <= 1'b0;
            jumping_o <= 1'b1;
        end else if (flush_i) begin
            // old stream gone, wait for the new one
            valid_o   <= 1'b0;
            jumping_o <= 1'b1;
        end else if (enable_i) begin
            // current output consumed
            valid_o <= head_valid_i;
            if (head_valid_i) begin
                // first entry of the new stream
                jumping_o <= 1'b0;
            end
        end
    end

    // pc and instruction hold unless a new entry is loaded
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_o          <= `FETCH_START_ADDR;
            instruction_o <= `FETCH_NOP;
        end else if (pop_o) begin
            pc_o          <= head_entry_i.pc;
            instruction_o <= head_entry_i.instr;
        end
    end

endmodule

// File: source/fetch_top.sv
/* instruction fetch stage top level
   request sequencer, prefetch buffer and issue register */

`include "fetch_config.svh"

module fetch_top (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             sys_reset_i,
    input  logic             enable_i,
    input  logic             jump_i,
    input  logic             ctx_switch_i,
    input  logic             busy_i,
    input  fetch_pkg::word_t jump_target_i,
    input  fetch_pkg::word_t ctx_switch_target_i,
    input  fetch_pkg::word_t instr_data_i,
    output logic             fetch_req_o,
    output fetch_pkg::word_t fetch_addr_o,
    output logic             valid_o,
    output fetch_pkg::word_t pc_o,
    output fetch_pkg::word_t instruction_o,
    output logic             jumping_o
);

    // sequencer to buffer and issue
    logic                    flush;
    logic                    push;
    fetch_pkg::fetch_entry_t push_entry;

    // buffer to sequencer and issue
    logic                    head_valid;
    fetch_pkg::fetch_entry_t head_entry;
    fetch_pkg::buf_count_t   free_count;

    // issue to buffer
    logic                    pop;

    //////////////////////////////////////////////////
    // memory side
    //////////////////////////////////////////////////

    fetch_sequencer i_sequencer (
        .clk                 (clk),
        .reset_n             (reset_n),
        .sys_reset_i         (sys_reset_i),
        .jump_i              (jump_i),
        .ctx_switch_i        (ctx_switch_i),
        .busy_i              (busy_i),
        .jump_target_i       (jump_target_i),
        .ctx_switch_target_i (ctx_switch_target_i),
        .instr_data_i        (instr_data_i),
        .free_count_i        (free_count),
        .fetch_req_o         (fetch_req_o),
        .fetch_addr_o        (fetch_addr_o),
        .flush_o             (flush),
        .push_o              (push),
        .push_entry_o        (push_entry)
    );

    // every fetched word passes through here
    fetch_buffer i_buffer (
        .clk          (clk),
        .reset_n      (reset_n),
        .flush_i      (flush),
        .push_i       (push),
        .pop_i        (pop),
        .push_entry_i (push_entry),
        .head_valid_o (head_valid),
        .head_entry_o (head_entry),
        .free_count_o (free_count)
    );

    //////////////////////////////////////////////////
    // decode side
    //////////////////////////////////////////////////

    fetch_issue i_issue (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable_i      (enable_i),
        .flush_i       (flush),
        .head_valid_i  (head_valid),
        .head_entry_i  (head_entry),
        .pop_o         (pop),
        .valid_o       (valid_o),
        .jumping_o     (jumping_o),
        .pc_o          (pc_o),
        .instruction_o (instruction_o)
    );

endmodule

// File: dv/fetch_mem_model.sv
/* testbench instruction memory
   one-cycle read latency and LFSR-driven busy */

module fetch_mem_model (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             fetch_req_i,
    input  fetch_pkg::word_t fetch_addr_i,
    input  logic [4:0]       busy_density_i,
    output logic             busy_o,
    output fetch_pkg::word_t instr_data_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam fetch_pkg::word_t DATA_XOR = 32'hA5A5_0000;

    logic [15:0]      lfsr_q;
    logic [3:0]       level;
    // request side as seen just before the edge
    logic             rst_s;
    logic             req_s;
    logic             busy_s;
    fetch_pkg::word_t addr_s;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    initial begin
        lfsr_q       = 16'd5;
        rst_s        = 1'b0;
        req_s        = 1'b0;
        busy_s       = 1'b0;
        addr_s       = '0;
        busy_o       = 1'b0;
        instr_data_o = '1;
    end

    // settled half a cycle after the edge
    always @(negedge clk) begin
        rst_s  = reset_n;
        req_s  = fetch_req_i;
        busy_s = busy_o;
        addr_s = fetch_addr_i;
    end

    always @(posedge clk) begin
        #1;
        // word valid for exactly the cycle after acceptance
        if (rst_s && req_s && !busy_s) begin
            instr_data_o = addr_s ^ DATA_XOR;
        end else begin
            instr_data_o = '1;
        end
        // four fresh bits per cycle against the density
        for (int i = 0; i < 4; i++) begin
            lfsr_q   = lfsr_next(lfsr_q);
            level[i] = lfsr_q[0];
        end
        busy_o = ({1'b0, level} < busy_density_i);
    end

endmodule

// File: dv/fetch_tb.sv
/* fetch stage testbench
   clock, reset, stimulus table, scoreboard and checks */

`include "fetch_config.svh"

module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam fetch_pkg::word_t START_ADDR = `FETCH_START_ADDR;
    localparam fetch_pkg::word_t NOP_INSTR  = `FETCH_NOP;
    localparam fetch_pkg::word_t DATA_XOR   = 32'hA5A5_0000;
    localparam int WAIT_LIMIT = 200;
    localparam int NUM_ROWS   = 9;

    typedef enum logic [2:0] {KIND_NONE, KIND_JUMP, KIND_CTX, KIND_BOTH, KIND_SYS} redirect_kind_t;

    // redirect goes first, then the random traffic
    typedef struct packed {
        logic [15:0]      cycles;
        logic [4:0]       enable_density;
        logic [4:0]       busy_density;
        redirect_kind_t   kind;
        fetch_pkg::word_t jump_target;
        fetch_pkg::word_t ctx_target;
    } stim_row_t;

    // densities out of 16
    stim_row_t stim_rows [NUM_ROWS] = '{
        '{16'd40, 5'd16, 5'd0,  KIND_NONE, 32'h0000_0000, 32'h0000_0000},
        '{16'd80, 5'd8,  5'd6,  KIND_NONE, 32'h0000_0000, 32'h0000_0000},
        '{16'd20, 5'd0,  5'd4,  KIND_NONE, 32'h0000_0000, 32'h0000_0000},
        '{16'd60, 5'd12, 5'd4,  KIND_JUMP, 32'h0000_2000, 32'h0000_0000},
        '{16'd60, 5'd10, 5'd8,  KIND_CTX,  32'h0000_0000, 32'h0000_4002},
        '{16'd60, 5'd16, 5'd2,  KIND_BOTH, 32'h0000_6000, 32'h0000_8001},
        '{16'd60, 5'd6,  5'd10, KIND_SYS,  32'h0000_7000, 32'h0000_9000},
        '{16'd40, 5'd14, 5'd3,  KIND_JUMP, 32'h0001_0003, 32'h0000_0000},
        '{16'd60, 5'd9,  5'd5,  KIND_NONE, 32'h0000_0000, 32'h0000_0000}
    };

    logic             clk;
    logic             reset_n;
    logic             sys_reset;
    logic             enable;
    logic             jump;
    logic             ctx_switch;
    logic             busy;
    logic [4:0]       busy_density;
    fetch_pkg::word_t jump_target;
    fetch_pkg::word_t ctx_target;
    fetch_pkg::word_t instr_data;
    logic             fetch_req;
    fetch_pkg::word_t fetch_addr;
    logic             valid;
    fetch_pkg::word_t pc;
    fetch_pkg::word_t instruction;
    logic             jumping;

    // scoreboard state
    fetch_pkg::word_t exp_pc;
    logic             redirect_seen;
    logic             hold_pending;
    logic             prev_valid;
    fetch_pkg::word_t prev_pc;
    fetch_pkg::word_t prev_instr;
    logic [15:0]      lfsr_q;
    logic             issued;

    fetch_top i_dut (
        .clk                 (clk),
        .reset_n             (reset_n),
        .sys_reset_i         (sys_reset),
        .enable_i            (enable),
        .jump_i              (jump),
        .ctx_switch_i        (ctx_switch),
        .busy_i              (busy),
        .jump_target_i       (jump_target),
        .ctx_switch_target_i (ctx_target),
        .instr_data_i        (instr_data),
        .fetch_req_o         (fetch_req),
        .fetch_addr_o        (fetch_addr),
        .valid_o             (valid),
        .pc_o                (pc),
        .instruction_o       (instruction),
        .jumping_o           (jumping)
    );

    fetch_mem_model i_mem (
        .clk            (clk),
        .reset_n        (reset_n),
        .fetch_req_i    (fetch_req),
        .fetch_addr_i   (fetch_addr),
        .busy_density_i (busy_density),
        .busy_o         (busy),
        .instr_data_o   (instr_data)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // same polynomial as the memory model
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic draw_level(output logic [3:0] level);
        for (int i = 0; i < 4; i++) begin
            lfsr_q   = lfsr_next(lfsr_q);
            level[i] = lfsr_q[0];
        end
    endtask

    task automatic halt_run();
        $display("Errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input fetch_pkg::word_t expected,
                               input fetch_pkg::word_t actual);
        assert (actual == expected) else begin
            $display("** Error: %s expected 0x%h actual 0x%h", name, expected, actual);
            halt_run();
        end
    endtask

    // outputs as decode sees them at the coming edge
    task automatic check_cycle(output logic took);
        logic             redirect;
        fetch_pkg::word_t target;
        redirect = sys_reset || ctx_switch || jump;
        if (sys_reset) begin
            target = START_ADDR;
        end else if (ctx_switch) begin
            target = ctx_target;
        end else begin
            target = jump_target;
        end
        check_value("fetch_addr_o[1:0]", '0, fetch_pkg::word_t'(fetch_addr[1:0]));
        if (redirect_seen) begin
            check_value("valid_o", 32'd0, fetch_pkg::word_t'(valid));
            check_value("jumping_o", 32'd1, fetch_pkg::word_t'(jumping));
        end
        // decode stalled at the last edge
        if (hold_pending) begin
            check_value("valid_o", fetch_pkg::word_t'(prev_valid), fetch_pkg::word_t'(valid));
            check_value("pc_o", prev_pc, pc);
            check_value("instruction_o", prev_instr, instruction);
        end
        took = valid && enable;
        if (took) begin
            check_value("pc_o", exp_pc, pc);
            check_value("instruction_o", exp_pc ^ DATA_XOR, instruction);
            // first entry of the stream already loaded
            check_value("jumping_o", 32'd0, fetch_pkg::word_t'(jumping));
            exp_pc = exp_pc + 32'd4;
        end
        redirect_seen = redirect;
        hold_pending  = !enable && !redirect;
        prev_valid    = valid;
        prev_pc       = pc;
        prev_instr    = instruction;
        if (redirect) begin
            exp_pc = {target[`FETCH_XLEN-1:2], 2'b00};
        end
    endtask

    // drive just after the edge, check at the falling edge
    task automatic run_cycle(input logic [4:0] en_dens, input redirect_kind_t kind,
                             input fetch_pkg::word_t jt, input fetch_pkg::word_t ct,
                             output logic took);
        logic [3:0] level;
        @(posedge clk);
        #1;
        draw_level(level);
        enable      = (kind == KIND_NONE) && ({1'b0, level} < en_dens);
        jump        = (kind == KIND_JUMP) || (kind == KIND_BOTH);
        ctx_switch  = (kind == KIND_CTX) || (kind == KIND_BOTH);
        sys_reset   = (kind == KIND_SYS);
        jump_target = jt;
        ctx_target  = ct;
        @(negedge clk);
        check_cycle(took);
    endtask

    task automatic wait_first_issue(input logic [4:0] en_dens);
        int   count;
        logic took;
        count = 0;
        took  = 1'b0;
        while (!took && count < WAIT_LIMIT) begin
            run_cycle(en_dens, KIND_NONE, '0, '0, took);
            count++;
        end
        assert (took) else begin
            $display("timeout, no instruction arrived within %0d cycles after a redirect",
                     WAIT_LIMIT);
            halt_run();
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        clk           = 1'b0;
        reset_n       = 1'b0;
        // system reset held too, so no request goes out during reset
        sys_reset     = 1'b1;
        enable        = 1'b0;
        jump          = 1'b0;
        ctx_switch    = 1'b0;
        jump_target   = '0;
        ctx_target    = '0;
        busy_density  = 5'd0;
        lfsr_q        = 16'd5;
        exp_pc        = START_ADDR;
        redirect_seen = 1'b0;
        hold_pending  = 1'b0;
        prev_valid    = 1'b0;
        prev_pc       = '0;
        prev_instr    = '0;
        issued        = 1'b0;

        // three cycles of reset, values checked before release
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("fetch_req_o", 32'd0, fetch_pkg::word_t'(fetch_req));
        check_value("valid_o", 32'd0, fetch_pkg::word_t'(valid));
        check_value("jumping_o", 32'd1, fetch_pkg::word_t'(jumping));
        check_value("pc_o", START_ADDR, pc);
        check_value("instruction_o", NOP_INSTR, instruction);
        @(posedge clk);
        #1;
        reset_n   = 1'b1;
        sys_reset = 1'b0;
        wait_first_issue(5'd16);

        for (int r = 0; r < NUM_ROWS; r++) begin
            busy_density = stim_rows[r].busy_density;
            if (stim_rows[r].kind != KIND_NONE) begin
                run_cycle(5'd0, stim_rows[r].kind, stim_rows[r].jump_target,
                          stim_rows[r].ctx_target, issued);
                wait_first_issue(stim_rows[r].enable_density);
            end
            for (int c = 0; c < int'(stim_rows[r].cycles); c++) begin
                run_cycle(stim_rows[r].enable_density, KIND_NONE, '0, '0, issued);
            end
        end

        @(posedge clk);
        $display("No errors");
        $finish;
    end

endmodule

// File: all.f
+incdir+source
source/fetch_pkg.sv
source/fetch_sequencer.sv
source/fetch_buffer.sv
source/fetch_issue.sv
source/fetch_top.sv
dv/fetch_mem_model.sv
dv/fetch_tb.sv

// File: run.sh
#!/bin/sh
# build and run the fetch stage testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module fetch_tb -f all.f -Mdir obj_dir -o fetch_sim > build.log 2>&1 \
    && ./obj_dir/fetch_sim > sim.log 2>&1 \
    ; grep -q "^No errors$" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }
